// File: dma_pkg.sv
// dma engine shared definitions
package dma_pkg;

   // bus and command widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int LEN_W  = 16;
   localparam int ID_W   = 1;

   // burst shape
   localparam int BURST_LEN  = 16;
   localparam int BEAT_BYTES = 4;

   // ******************************
   // fixed AXI sideband values
   // ******************************
   localparam logic [2:0] AXI_SIZE       = 3'd2;
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   // bufferable and modifiable
   localparam logic [3:0] AXI_CACHE      = 4'b0011;
   localparam logic       AXI_LOCK       = 1'b0;
   localparam logic [2:0] AXI_PROT       = 3'b000;
   localparam logic [3:0] AXI_QOS        = 4'h0;
   localparam logic [ID_W-1:0]   AXI_ID   = '0;
   // all byte lanes written
   localparam logic [STRB_W-1:0] AXI_STRB = '1;

   // payload types
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [LEN_W-1:0]  len_t;
   typedef logic [7:0]        axlen_t;

endpackage

// File: dma_cmd_reg.sv
// dma command register
`timescale 1ns/1ps

module dma_cmd_reg
(
   input  logic           m_axi_aclk,
   input  logic           m_axi_aresetn,
   input  logic           init,
   input  dma_pkg::addr_t addr,
   input  dma_pkg::len_t  len,
   input  logic           cmd_done,
   output logic           cmd_start,
   output dma_pkg::addr_t cmd_addr,
   output dma_pkg::len_t  cmd_len,
   output logic           busy,
   output logic           done
);

   logic init_d;
   logic init_dd;
   logic accept;

   // rising edge of init, only taken while idle
   assign accept = init_d && !init_dd && !busy;

   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         init_d    <= 1'b0;
         init_dd   <= 1'b0;
         cmd_start <= 1'b0;
         busy      <= 1'b0;
         done      <= 1'b0;
      end
      else
      begin
         init_d    <= init;
         init_dd   <= init_d;
         cmd_start <= accept;
         done      <= cmd_done;
         if (accept)
            busy <= 1'b1;
         else if (cmd_done)
            busy <= 1'b0;
      end
   end

   // command stays put until the next accepted edge
   always_ff @(posedge m_axi_aclk)
   begin
      if (accept)
      begin
         cmd_addr <= addr;
         cmd_len  <= len;
      end
   end

endmodule

// File: dma_burst_sched.sv
// dma burst scheduler
`timescale 1ns/1ps

module dma_burst_sched
(
   input  logic            m_axi_aclk,
   input  logic            m_axi_aresetn,
   input  logic            cmd_start,
   input  dma_pkg::addr_t  cmd_addr,
   input  dma_pkg::len_t   cmd_len,
   input  logic            ax_ready,
   input  logic            burst_done,
   output logic            ax_valid,
   output dma_pkg::addr_t  ax_addr,
   output dma_pkg::axlen_t ax_len,
   output logic            cmd_done
);

   import dma_pkg::*;

   // beats not yet issued and the address they start at
   len_t  remaining;
   addr_t next_addr;

   // the burst about to go out
   addr_t src_addr;
   len_t  src_len;
   len_t  beats;
   logic  issue;

   assign src_addr = cmd_start ? cmd_addr : next_addr;
   assign src_len  = cmd_start ? cmd_len : remaining;
   assign beats    = (src_len > len_t'(BURST_LEN)) ? len_t'(BURST_LEN) : src_len;

   // first burst on start, later ones once the previous burst has finished
   assign issue    = cmd_start || (burst_done && remaining != '0);
   assign cmd_done = burst_done && remaining == '0;

   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         ax_valid  <= 1'b0;
         remaining <= '0;
      end
      else if (issue)
      begin
         ax_valid  <= 1'b1;
         remaining <= src_len - beats;
      end
      else if (ax_valid && ax_ready)
      begin
         ax_valid <= 1'b0;
      end
   end

   // address channel payload, held while valid waits for ready
   always_ff @(posedge m_axi_aclk)
   begin
      if (issue)
      begin
         ax_addr   <= src_addr;
         ax_len    <= axlen_t'(beats - len_t'(1));
         next_addr <= src_addr + addr_t'(beats) * addr_t'(BEAT_BYTES);
      end
   end

endmodule

// File: dma_write_data.sv
// dma write data and response
`timescale 1ns/1ps

module dma_write_data
(
   input  logic            m_axi_aclk,
   input  logic            m_axi_aresetn,
   input  logic            aw_valid,
   input  logic            aw_ready,
   input  dma_pkg::axlen_t aw_len,
   input  dma_pkg::data_t  wr_data,
   input  logic            w_ready,
   input  logic            b_valid,
   input  logic [1:0]      b_resp,
   input  logic            cmd_start,
   output logic            w_valid,
   output logic            w_last,
   output dma_pkg::data_t  w_data,
   output logic            b_ready,
   output logic            wr_ready,
   output logic            wr_err,
   output logic            burst_done
);

   import dma_pkg::*;

   // beats left after the one on the bus
   axlen_t beat_cnt;
   logic   aw_hs;
   logic   w_hs;
   logic   b_hs;

   assign aw_hs = aw_valid && aw_ready;
   assign w_hs  = w_valid && w_ready;
   assign b_hs  = b_valid && b_ready;

   // user word is show-ahead so it drives the bus directly
   assign w_data   = wr_data;
   assign wr_ready = w_hs;

   // ******************************
   // W channel
   // ******************************
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         w_valid  <= 1'b0;
         w_last   <= 1'b0;
         beat_cnt <= '0;
      end
      else if (aw_hs)
      begin
         w_valid  <= 1'b1;
         w_last   <= (aw_len == '0);
         beat_cnt <= aw_len;
      end
      else if (w_hs)
      begin
         if (w_last)
         begin
            w_valid <= 1'b0;
            w_last  <= 1'b0;
         end
         else
         begin
            w_last   <= (beat_cnt == axlen_t'(1));
            beat_cnt <= beat_cnt - axlen_t'(1);
         end
      end
   end

   // ******************************
   // B channel
   // ******************************
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         b_ready    <= 1'b0;
         wr_err     <= 1'b0;
         burst_done <= 1'b0;
      end
      else
      begin
         burst_done <= b_hs;
         if (w_hs && w_last)
            b_ready <= 1'b1;
         else if (b_hs)
            b_ready <= 1'b0;
         // sticky over the whole command
         if (cmd_start)
            wr_err <= 1'b0;
         else if (b_hs && b_resp != 2'b00)
            wr_err <= 1'b1;
      end
   end

endmodule

// File: dma_read_data.sv
// dma read data
`timescale 1ns/1ps

module dma_read_data
(
   input  logic           m_axi_aclk,
   input  logic           m_axi_aresetn,
   input  logic           ar_valid,
   input  logic           ar_ready,
   input  logic           r_valid,
   input  logic           r_last,
   input  dma_pkg::data_t r_data,
   output logic           r_ready,
   output dma_pkg::data_t rd_data,
   output logic           rd_valid,
   output logic           burst_done
);

   logic ar_hs;
   logic r_hs;

   assign ar_hs = ar_valid && ar_ready;
   assign r_hs  = r_valid && r_ready;

   // rready open for exactly one burst
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         r_ready    <= 1'b0;
         rd_valid   <= 1'b0;
         burst_done <= 1'b0;
      end
      else
      begin
         rd_valid   <= r_hs;
         burst_done <= r_hs && r_last;
         if (ar_hs)
            r_ready <= 1'b1;
         else if (r_hs && r_last)
            r_ready <= 1'b0;
      end
   end

   // word to the user alongside the strobe
   always_ff @(posedge m_axi_aclk)
   begin
      if (r_hs)
         rd_data <= r_data;
   end

endmodule

// File: m_axi_dma.sv
// AXI4 master dma engine
`timescale 1ns/1ps

module m_axi_dma
(
   input  logic                       m_axi_aclk,
   input  logic                       m_axi_aresetn,
   // write address channel
   output logic [dma_pkg::ID_W-1:0]   m_axi_awid,
   output dma_pkg::addr_t             m_axi_awaddr,
   output dma_pkg::axlen_t            m_axi_awlen,
   output logic [2:0]                 m_axi_awsize,
   output logic [1:0]                 m_axi_awburst,
   output logic                       m_axi_awlock,
   output logic [3:0]                 m_axi_awcache,
   output logic [2:0]                 m_axi_awprot,
   output logic [3:0]                 m_axi_awqos,
   output logic                       m_axi_awvalid,
   input  logic                       m_axi_awready,
   // write data channel
   output dma_pkg::data_t             m_axi_wdata,
   output logic [dma_pkg::STRB_W-1:0] m_axi_wstrb,
   output logic                       m_axi_wlast,
   output logic                       m_axi_wvalid,
   input  logic                       m_axi_wready,
   // write response channel
   input  logic [dma_pkg::ID_W-1:0]   m_axi_bid,
   input  logic [1:0]                 m_axi_bresp,
   input  logic                       m_axi_bvalid,
   output logic                       m_axi_bready,
   // read address channel
   output logic [dma_pkg::ID_W-1:0]   m_axi_arid,
   output dma_pkg::addr_t             m_axi_araddr,
   output dma_pkg::axlen_t            m_axi_arlen,
   output logic [2:0]                 m_axi_arsize,
   output logic [1:0]                 m_axi_arburst,
   output logic                       m_axi_arlock,
   output logic [3:0]                 m_axi_arcache,
   output logic [2:0]                 m_axi_arprot,
   output logic [3:0]                 m_axi_arqos,
   output logic                       m_axi_arvalid,
   input  logic                       m_axi_arready,
   // read data channel
   input  logic [dma_pkg::ID_W-1:0]   m_axi_rid,
   input  dma_pkg::data_t             m_axi_rdata,
   input  logic [1:0]                 m_axi_rresp,
   input  logic                       m_axi_rlast,
   input  logic                       m_axi_rvalid,
   output logic                       m_axi_rready,
   // user write side
   input  dma_pkg::addr_t             dma_wraddr,
   input  dma_pkg::len_t              dma_wrlen,
   input  logic                       dma_wrinit,
   input  dma_pkg::data_t             dma_wrdata,
   output logic                       dma_wrready,
   output logic                       dma_wrbusy,
   output logic                       dma_wrdone,
   output logic                       dma_wrerr,
   // user read side
   input  dma_pkg::addr_t             dma_rdaddr,
   input  dma_pkg::len_t              dma_rdlen,
   input  logic                       dma_rdinit,
   output dma_pkg::data_t             dma_rddata,
   output logic                       dma_rdvalid,
   output logic                       dma_rdbusy,
   output logic                       dma_rddone
);

   import dma_pkg::*;

   logic  wr_cmd_start;
   addr_t wr_cmd_addr;
   len_t  wr_cmd_len;
   logic  wr_cmd_done;
   logic  wr_burst_done;
   logic  rd_cmd_start;
   addr_t rd_cmd_addr;
   len_t  rd_cmd_len;
   logic  rd_cmd_done;
   logic  rd_burst_done;

   // ******************************
   // fixed sideband
   // ******************************
   assign m_axi_awid    = AXI_ID;
   assign m_axi_awsize  = AXI_SIZE;
   assign m_axi_awburst = AXI_BURST_INCR;
   assign m_axi_awlock  = AXI_LOCK;
   assign m_axi_awcache = AXI_CACHE;
   assign m_axi_awprot  = AXI_PROT;
   assign m_axi_awqos   = AXI_QOS;
   assign m_axi_wstrb   = AXI_STRB;
   assign m_axi_arid    = AXI_ID;
   assign m_axi_arsize  = AXI_SIZE;
   assign m_axi_arburst = AXI_BURST_INCR;
   assign m_axi_arlock  = AXI_LOCK;
   assign m_axi_arcache = AXI_CACHE;
   assign m_axi_arprot  = AXI_PROT;
   assign m_axi_arqos   = AXI_QOS;

   // ******************************
   // write direction
   // ******************************
   dma_cmd_reg u_wr_cmd
   (
      .m_axi_aclk,
      .m_axi_aresetn,
      .init      (dma_wrinit),
      .addr      (dma_wraddr),
      .len       (dma_wrlen),
      .cmd_done  (wr_cmd_done),
      .cmd_start (wr_cmd_start),
      .cmd_addr  (wr_cmd_addr),
      .cmd_len   (wr_cmd_len),
      .busy      (dma_wrbusy),
      .done      (dma_wrdone)
   );

   dma_burst_sched u_wr_sched
   (
      .m_axi_aclk,
      .m_axi_aresetn,
      .cmd_start  (wr_cmd_start),
      .cmd_addr   (wr_cmd_addr),
      .cmd_len    (wr_cmd_len),
      .ax_ready   (m_axi_awready),
      .burst_done (wr_burst_done),
      .ax_valid   (m_axi_awvalid),
      .ax_addr    (m_axi_awaddr),
      .ax_len     (m_axi_awlen),
      .cmd_done   (wr_cmd_done)
   );

   dma_write_data u_wr_data
   (
      .m_axi_aclk,
      .m_axi_aresetn,
      .aw_valid   (m_axi_awvalid),
      .aw_ready   (m_axi_awready),
      .aw_len     (m_axi_awlen),
      .wr_data    (dma_wrdata),
      .w_ready    (m_axi_wready),
      .b_valid    (m_axi_bvalid),
      .b_resp     (m_axi_bresp),
      .cmd_start  (wr_cmd_start),
      .w_valid    (m_axi_wvalid),
      .w_last     (m_axi_wlast),
      .w_data     (m_axi_wdata),
      .b_ready    (m_axi_bready),
      .wr_ready   (dma_wrready),
      .wr_err     (dma_wrerr),
      .burst_done (wr_burst_done)
   );

   // ******************************
   // read direction
   // ******************************
   dma_cmd_reg u_rd_cmd
   (
      .m_axi_aclk,
      .m_axi_aresetn,
      .init      (dma_rdinit),
      .addr      (dma_rdaddr),
      .len       (dma_rdlen),
      .cmd_done  (rd_cmd_done),
      .cmd_start (rd_cmd_start),
      .cmd_addr  (rd_cmd_addr),
      .cmd_len   (rd_cmd_len),
      .busy      (dma_rdbusy),
      .done      (dma_rddone)
   );

   dma_burst_sched u_rd_sched
   (
      .m_axi_aclk,
      .m_axi_aresetn,
      .cmd_start  (rd_cmd_start),
      .cmd_addr   (rd_cmd_addr),
      .cmd_len    (rd_cmd_len),
      .ax_ready   (m_axi_arready),
      .burst_done (rd_burst_done),
      .ax_valid   (m_axi_arvalid),
      .ax_addr    (m_axi_araddr),
      .ax_len     (m_axi_arlen),
      .cmd_done   (rd_cmd_done)
   );

   dma_read_data u_rd_data
   (
      .m_axi_aclk,
      .m_axi_aresetn,
      .ar_valid   (m_axi_arvalid),
      .ar_ready   (m_axi_arready),
      .r_valid    (m_axi_rvalid),
      .r_last     (m_axi_rlast),
      .r_data     (m_axi_rdata),
      .r_ready    (m_axi_rready),
      .rd_data    (dma_rddata),
      .rd_valid   (dma_rdvalid),
      .burst_done (rd_burst_done)
   );

endmodule

// File: tb_axi_mem.sv
// AXI slave memory model
`timescale 1ns/1ps

module tb_axi_mem
(
   input  logic            m_axi_aclk,
   input  logic            m_axi_aresetn,
   input  logic            slv_err,
   input  dma_pkg::addr_t  awaddr,
   input  dma_pkg::axlen_t awlen,
   input  logic            awvalid,
   output logic            awready,
   input  dma_pkg::data_t  wdata,
   input  logic            wlast,
   input  logic            wvalid,
   output logic            wready,
   output logic [1:0]      bresp,
   output logic            bvalid,
   input  logic            bready,
   input  dma_pkg::addr_t  araddr,
   input  dma_pkg::axlen_t arlen,
   input  logic            arvalid,
   output logic            arready,
   output dma_pkg::data_t  rdata,
   output logic            rlast,
   output logic            rvalid,
   input  logic            rready
);

   import dma_pkg::*;

   localparam int DEPTH   = 1024;
   localparam int LOG_MAX = 256;

   data_t  mem [0:DEPTH-1];

   // address handshakes in the order they happened
   addr_t  aw_log_addr [0:LOG_MAX-1];
   axlen_t aw_log_len  [0:LOG_MAX-1];
   int     aw_log_n;
   addr_t  ar_log_addr [0:LOG_MAX-1];
   axlen_t ar_log_len  [0:LOG_MAX-1];
   int     ar_log_n;
   // W beats whose wlast disagreed with awlen
   int     wlast_errs;

   logic   w_active;
   addr_t  w_addr;
   axlen_t w_left;
   logic   b_pend;
   logic   b_err;
   logic   r_active;
   addr_t  r_addr;
   axlen_t r_left;
   logic   r_hs;

   initial
   begin
      // background pattern from the byte address
      for (int i = 0; i < DEPTH; i++)
         mem[i] = ~data_t'(i * BEAT_BYTES);
      aw_log_n   = 0;
      ar_log_n   = 0;
      wlast_errs = 0;
      w_active   = 1'b0;
      b_pend     = 1'b0;
      b_err      = 1'b0;
      r_active   = 1'b0;
      awready    = 1'b0;
      wready     = 1'b0;
      bvalid     = 1'b0;
      bresp      = 2'b00;
      arready    = 1'b0;
      rvalid     = 1'b0;
      rlast      = 1'b0;
      rdata      = '0;
   end

   always @(posedge m_axi_aclk)
   begin
      r_hs = rvalid && rready;
      if (!m_axi_aresetn)
      begin
         w_active = 1'b0;
         b_pend   = 1'b0;
         r_active = 1'b0;
      end
      else
      begin
         // ******************************
         // write side
         // ******************************
         if (awvalid && awready)
         begin
            aw_log_addr[aw_log_n] = awaddr;
            aw_log_len[aw_log_n]  = awlen;
            aw_log_n = aw_log_n + 1;
            w_addr   = awaddr;
            w_left   = awlen;
            w_active = 1'b1;
         end
         if (wvalid && wready)
         begin
            mem[w_addr[11:2]] = wdata;
            if (wlast != (w_left == '0))
               wlast_errs = wlast_errs + 1;
            w_addr = w_addr + BEAT_BYTES;
            w_left = w_left - axlen_t'(1);
            if (wlast)
            begin
               w_active = 1'b0;
               b_pend   = 1'b1;
               b_err    = slv_err;
            end
         end
         if (bvalid && bready)
            b_pend = 1'b0;
         // ******************************
         // read side
         // ******************************
         if (arvalid && arready)
         begin
            ar_log_addr[ar_log_n] = araddr;
            ar_log_len[ar_log_n]  = arlen;
            ar_log_n = ar_log_n + 1;
            r_addr   = araddr;
            r_left   = arlen;
            r_active = 1'b1;
         end
         if (r_hs)
         begin
            r_addr = r_addr + BEAT_BYTES;
            if (r_left == '0)
               r_active = 1'b0;
            else
               r_left = r_left - axlen_t'(1);
         end
      end
      // outputs move a little after the edge
      #1;
      awready = m_axi_aresetn && !w_active && !b_pend && (($urandom % 4) != 0);
      wready  = m_axi_aresetn && w_active && (($urandom % 4) != 0);
      bvalid  = m_axi_aresetn && b_pend;
      bresp   = b_err ? 2'b10 : 2'b00;
      arready = m_axi_aresetn && !r_active && (($urandom % 4) != 0);
      // a beat on offer stays until taken
      if (!(rvalid && !r_hs))
         rvalid = m_axi_aresetn && r_active && (($urandom % 3) != 0);
      rdata = mem[r_addr[11:2]];
      rlast = (r_left == '0);
   end

endmodule

// File: tb_m_axi_dma.sv
// dma engine testbench
`timescale 1ns/1ps

module tb_m_axi_dma;

   import dma_pkg::*;

   localparam int    SEED      = 98;
   localparam real   PERIOD    = 8.0;
   localparam int    TIMEOUT   = 5000;
   localparam int    MAX_WORDS = 256;
   localparam string GOLDEN    = "dma_golden.txt";

   logic              m_axi_aclk;
   logic              m_axi_aresetn;
   logic [ID_W-1:0]   m_axi_awid, m_axi_bid, m_axi_arid, m_axi_rid;
   addr_t             m_axi_awaddr, m_axi_araddr;
   axlen_t            m_axi_awlen, m_axi_arlen;
   logic [2:0]        m_axi_awsize, m_axi_awprot, m_axi_arsize, m_axi_arprot;
   logic [1:0]        m_axi_awburst, m_axi_arburst, m_axi_bresp, m_axi_rresp;
   logic [3:0]        m_axi_awcache, m_axi_awqos, m_axi_arcache, m_axi_arqos;
   logic              m_axi_awlock, m_axi_awvalid, m_axi_awready;
   data_t             m_axi_wdata, m_axi_rdata;
   logic [STRB_W-1:0] m_axi_wstrb;
   logic              m_axi_wlast, m_axi_wvalid, m_axi_wready;
   logic              m_axi_bvalid, m_axi_bready;
   logic              m_axi_arlock, m_axi_arvalid, m_axi_arready;
   logic              m_axi_rlast, m_axi_rvalid, m_axi_rready;
   addr_t             dma_wraddr, dma_rdaddr;
   len_t              dma_wrlen, dma_rdlen;
   data_t             dma_wrdata, dma_rddata;
   logic              dma_wrinit, dma_wrready, dma_wrbusy, dma_wrdone, dma_wrerr;
   logic              dma_rdinit, dma_rdvalid, dma_rdbusy, dma_rddone;
   logic              slv_err;

   // words of the current golden record
   data_t             words [0:MAX_WORDS];

   m_axi_dma UUT (.*);

   tb_axi_mem u_mem
   (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .slv_err       (slv_err),
      .awaddr        (m_axi_awaddr),
      .awlen         (m_axi_awlen),
      .awvalid       (m_axi_awvalid),
      .awready       (m_axi_awready),
      .wdata         (m_axi_wdata),
      .wlast         (m_axi_wlast),
      .wvalid        (m_axi_wvalid),
      .wready        (m_axi_wready),
      .bresp         (m_axi_bresp),
      .bvalid        (m_axi_bvalid),
      .bready        (m_axi_bready),
      .araddr        (m_axi_araddr),
      .arlen         (m_axi_arlen),
      .arvalid       (m_axi_arvalid),
      .arready       (m_axi_arready),
      .rdata         (m_axi_rdata),
      .rlast         (m_axi_rlast),
      .rvalid        (m_axi_rvalid),
      .rready        (m_axi_rready)
   );

   initial
   begin
      m_axi_aclk = 1'b0;
      forever
         #(PERIOD / 2.0) m_axi_aclk = ~m_axi_aclk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_reset_state();
      check_value("m_axi_awvalid", m_axi_awvalid, 0);
      check_value("m_axi_wvalid", m_axi_wvalid, 0);
      check_value("m_axi_wlast", m_axi_wlast, 0);
      check_value("m_axi_bready", m_axi_bready, 0);
      check_value("m_axi_arvalid", m_axi_arvalid, 0);
      check_value("m_axi_rready", m_axi_rready, 0);
      check_value("dma_wrready", dma_wrready, 0);
      check_value("dma_wrbusy", dma_wrbusy, 0);
      check_value("dma_wrdone", dma_wrdone, 0);
      check_value("dma_wrerr", dma_wrerr, 0);
      check_value("dma_rdvalid", dma_rdvalid, 0);
      check_value("dma_rdbusy", dma_rdbusy, 0);
      check_value("dma_rddone", dma_rddone, 0);
   endtask

   // fixed sideband of incrementing 4-byte bursts with every lane written
   task automatic check_sideband();
      check_value("m_axi_awid", m_axi_awid, 0);
      check_value("m_axi_awsize", m_axi_awsize, 3'd2);
      check_value("m_axi_awburst", m_axi_awburst, 2'b01);
      check_value("m_axi_awlock", m_axi_awlock, 0);
      check_value("m_axi_awcache", m_axi_awcache, 4'b0011);
      check_value("m_axi_awprot", m_axi_awprot, 0);
      check_value("m_axi_awqos", m_axi_awqos, 0);
      check_value("m_axi_wstrb", m_axi_wstrb, 4'hf);
      check_value("m_axi_arid", m_axi_arid, 0);
      check_value("m_axi_arsize", m_axi_arsize, 3'd2);
      check_value("m_axi_arburst", m_axi_arburst, 2'b01);
      check_value("m_axi_arlock", m_axi_arlock, 0);
      check_value("m_axi_arcache", m_axi_arcache, 4'b0011);
      check_value("m_axi_arprot", m_axi_arprot, 0);
      check_value("m_axi_arqos", m_axi_arqos, 0);
   endtask

   // expected bursts from the splitting rule against the slave's log
   task automatic check_bursts(input addr_t addr, input len_t len, input int base,
                               input logic is_read);
      len_t  left;
      len_t  beats;
      addr_t a;
      int    i;
      left = len;
      a    = addr;
      i    = base;
      while (left != 0)
      begin
         beats = (left > BURST_LEN) ? len_t'(BURST_LEN) : left;
         if (is_read)
         begin
            check_value("m_axi_araddr", u_mem.ar_log_addr[i], a);
            check_value("m_axi_arlen", u_mem.ar_log_len[i], beats - 1);
         end
         else
         begin
            check_value("m_axi_awaddr", u_mem.aw_log_addr[i], a);
            check_value("m_axi_awlen", u_mem.aw_log_len[i], beats - 1);
         end
         a    = a + beats * BEAT_BYTES;
         left = left - beats;
         i    = i + 1;
      end
      if (is_read)
         check_value("ar handshake count", u_mem.ar_log_n, i);
      else
         check_value("aw handshake count", u_mem.aw_log_n, i);
   endtask

   task automatic run_write(input addr_t addr, input len_t len, input logic expect_err);
      int   base;
      int   idx;
      int   cyc;
      int   busy_cyc;
      logic done_seen;
      logic busy_last;
      base = u_mem.aw_log_n;
      @(posedge m_axi_aclk);
      #1;
      dma_wrinit = 1'b0;
      dma_wraddr = addr;
      dma_wrlen  = len;
      dma_wrdata = words[0];
      slv_err    = expect_err;
      // init low long enough for the edge detector
      repeat (3) @(posedge m_axi_aclk);
      #1;
      dma_wrinit = 1'b1;
      idx       = 0;
      cyc       = 0;
      busy_cyc  = 0;
      done_seen = 1'b0;
      busy_last = 1'b0;
      while (!done_seen)
      begin
         @(posedge m_axi_aclk);
         if (dma_wrready)
            idx = idx + 1;
         if (dma_wrbusy)
            busy_cyc = busy_cyc + 1;
         done_seen = dma_wrdone;
         // busy drops in the cycle of the done pulse
         if (done_seen)
            check_value("dma_wrbusy before dma_wrdone", busy_last, 1);
         busy_last = dma_wrbusy;
         cyc = cyc + 1;
         if (cyc > TIMEOUT)
            abort_run("timeout waiting for dma_wrdone");
         if (idx > len)
            abort_run("more write words taken than the command length");
         #1;
         dma_wrdata = words[idx];
         // second init edge while busy on long commands
         if (len > BURST_LEN && busy_cyc == 2)
            dma_wrinit = 1'b0;
         if (len > BURST_LEN && busy_cyc == 6)
            dma_wrinit = 1'b1;
      end
      check_value("dma_wrbusy", dma_wrbusy, 0);
      check_value("write words taken", idx, len);
      check_value("dma_wrerr", dma_wrerr, expect_err);
      repeat (4)
      begin
         @(posedge m_axi_aclk);
         check_value("dma_wrdone", dma_wrdone, 0);
         check_value("dma_wrbusy", dma_wrbusy, 0);
      end
      check_value("wlast mismatches", u_mem.wlast_errs, 0);
      check_bursts(addr, len, base, 1'b0);
      if (!expect_err)
      begin
         for (int k = 0; k < len; k++)
            check_value("memory word", u_mem.mem[(addr >> 2) + k], words[k]);
      end
   endtask

   task automatic run_read(input addr_t addr, input len_t len);
      int   base;
      int   idx;
      int   cyc;
      logic done_seen;
      logic busy_last;
      base = u_mem.ar_log_n;
      @(posedge m_axi_aclk);
      #1;
      dma_rdinit = 1'b0;
      dma_rdaddr = addr;
      dma_rdlen  = len;
      repeat (3) @(posedge m_axi_aclk);
      #1;
      dma_rdinit = 1'b1;
      idx       = 0;
      cyc       = 0;
      done_seen = 1'b0;
      busy_last = 1'b0;
      while (!done_seen)
      begin
         @(posedge m_axi_aclk);
         if (dma_rdvalid)
         begin
            if (idx >= len)
               abort_run("more read strobes than the command length");
            check_value("dma_rddata", dma_rddata, words[idx]);
            idx = idx + 1;
         end
         done_seen = dma_rddone;
         if (done_seen)
            check_value("dma_rdbusy before dma_rddone", busy_last, 1);
         busy_last = dma_rdbusy;
         cyc = cyc + 1;
         if (cyc > TIMEOUT)
            abort_run("timeout waiting for dma_rddone");
      end
      check_value("read strobes", idx, len);
      check_value("dma_rdbusy", dma_rdbusy, 0);
      repeat (4)
      begin
         @(posedge m_axi_aclk);
         check_value("dma_rddone", dma_rddone, 0);
         check_value("dma_rdvalid", dma_rdvalid, 0);
      end
      check_bursts(addr, len, base, 1'b1);
   endtask

   initial
   begin
      int unsigned seed_used;
      int          fd;
      int          got;
      int          records;
      string       kind;
      string       line;
      addr_t       addr;
      len_t        len;
      seed_used     = $urandom(SEED);
      m_axi_aresetn = 1'b0;
      m_axi_bid     = '0;
      m_axi_rid     = '0;
      m_axi_rresp   = 2'b00;
      dma_wraddr    = '0;
      dma_wrlen     = '0;
      dma_wrinit    = 1'b0;
      dma_wrdata    = '0;
      dma_rdaddr    = '0;
      dma_rdlen     = '0;
      dma_rdinit    = 1'b0;
      slv_err       = 1'b0;
      repeat (8) @(posedge m_axi_aclk);
      #1;
      m_axi_aresetn = 1'b1;
      @(posedge m_axi_aclk);
      check_reset_state();
      check_sideband();
      fd = $fopen(GOLDEN, "r");
      if (fd == 0)
         abort_run("cannot open the golden file dma_golden.txt");
      records = 0;
      while ($fscanf(fd, "%s", kind) == 1)
      begin
         if (kind[0] == "#")
            got = $fgets(line, fd);
         else
         begin
            got = $fscanf(fd, "%h %h", addr, len);
            if (got != 2 || len == 0 || len > MAX_WORDS)
               abort_run("bad command line in the golden file");
            for (int k = 0; k < len; k++)
            begin
               got = $fscanf(fd, "%h", words[k]);
               if (got != 1)
                  abort_run("golden file ends inside a record");
            end
            if (kind == "R")
               run_read(addr, len);
            else if (kind == "W" || kind == "E")
               run_write(addr, len, kind == "E");
            else
               abort_run("unknown record kind in the golden file");
            records = records + 1;
         end
      end
      $fclose(fd);
      if (records > 0)
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
      begin
         $display("no records found in the golden file");
         $display("FAIL: see errors above");
         $fatal(1);
      end
   end

endmodule

// File: dma_golden.txt
# kind addr len : W write, R read and compare, E write answered with SLVERR
# addr and len in hex, then len data words in hex over any number of lines
W 00000100 0005
  0badf00d 12345678 9abcdef0 00000001 fffffffe
W 00000400 0025
  5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0004 5a5a0005 5a5a0006 5a5a0007 5a5a0008 5a5a0009
  6b6b000a 6b6b000b 6b6b000c 6b6b000d 6b6b000e 6b6b000f 6b6b0010 6b6b0011 6b6b0012 6b6b0013
  7c7c0014 7c7c0015 7c7c0016 7c7c0017 7c7c0018 7c7c0019 7c7c001a 7c7c001b 7c7c001c 7c7c001d
  8d8d001e 8d8d001f 8d8d0020 8d8d0021 8d8d0022 8d8d0023 8d8d0024
R 00000400 0025
  5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0004 5a5a0005 5a5a0006 5a5a0007 5a5a0008 5a5a0009
  6b6b000a 6b6b000b 6b6b000c 6b6b000d 6b6b000e 6b6b000f 6b6b0010 6b6b0011 6b6b0012 6b6b0013
  7c7c0014 7c7c0015 7c7c0016 7c7c0017 7c7c0018 7c7c0019 7c7c001a 7c7c001b 7c7c001c 7c7c001d
  8d8d001e 8d8d001f 8d8d0020 8d8d0021 8d8d0022 8d8d0023 8d8d0024
R 00000100 0005
  0badf00d 12345678 9abcdef0 00000001 fffffffe
E 00000800 0003
  deadbeef cafef00d 01020304
W 00000900 0002
  13579bdf 2468ace0
R 00000900 0002
  13579bdf 2468ace0

// File: verilog.f
dma_pkg.sv
dma_cmd_reg.sv
dma_burst_sched.sv
dma_write_data.sv
dma_read_data.sv
m_axi_dma.sv
tb_axi_mem.sv
tb_m_axi_dma.sv

// File: Bender.yml
package:
  name: m_axi_dma

sources:
  - dma_pkg.sv
  - dma_cmd_reg.sv
  - dma_burst_sched.sv
  - dma_write_data.sv
  - dma_read_data.sv
  - m_axi_dma.sv
  - target: simulation
    files:
      - tb_axi_mem.sv
      - tb_m_axi_dma.sv
